//--- Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -j 0
TOP        = tb_qla_reg_core
FILELIST   = files.f
OBJ_DIR    = obj_dir
PASS_MSG   = test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | awk -v msg="$(PASS_MSG)" \
		'{ print } $$0 == msg { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

//--- common/qla_macros.svh
// qla register core constants: address spaces, offsets and counts
`ifndef QLA_MACROS_SVH
`define QLA_MACROS_SVH

// ----------------------------------------
// address spaces, compared with addr[15:12]
// ----------------------------------------
`define QLA_ADDR_MAIN       4'h0    // board and channel registers
`define QLA_ADDR_FIR        4'h8    // fir coefficient staging

// ----------------------------------------
// per-channel offsets, addr[3:0]
// ----------------------------------------
`define QLA_OFF_DAC_CTRL    4'h1    // commanded current

// channels 1..4 live in addr[7:4]
`define QLA_NUM_CHANNELS    4

// ----------------------------------------
// fir reload
// ----------------------------------------
`define QLA_NUM_COEFFS      15      // taps per filter

// addr bit picking the filter, 1 is pot and 0 is cur
`define QLA_FIR_SEL_BIT     11

`endif

//--- common/qla_pkg.sv
// qla register core package: bus, coefficient and command types shared by the design
package qla_pkg;

    // ----------------------------------------
    // register bus
    // ----------------------------------------
    typedef logic [15:0] reg_addr_t;   // space[15:12] | fir sel[11] | chan[7:4] | offset[3:0]
    typedef logic [31:0] reg_data_t;   // quadlet

    // channel field of an address, 0 is the global channel
    typedef logic [3:0]  chan_t;

    // ----------------------------------------
    // fir coefficient reload
    // ----------------------------------------
    typedef logic [15:0] coeff_t;      // one tap, low half of the quadlet
    typedef logic [3:0]  coeff_idx_t;  // tap index 0..14, 15 unused

    // loader fsm
    typedef enum logic {
        ST_STAGING   = 1'b0,           // collecting writes
        ST_STREAMING = 1'b1            // feeding the filter core
    } reload_state_t;

    // ----------------------------------------
    // dac
    // ----------------------------------------
    typedef logic [15:0] cur_cmd_t;    // commanded current, dac code

endpackage

//--- common/reg_write_if.sv
// register write bus: the arbitrated write bundle seen by every register block
`timescale 1ns/1ps

interface reg_write_if import qla_pkg::*; ();

    logic      wen;      // quadlet or block write strobe
    logic      blk_wen;  // block write, marks a real-time update
    reg_addr_t waddr;    // write address
    reg_data_t wdata;    // write data

    // driven by the arbiter
    modport source (
        output wen, blk_wen, waddr, wdata
    );

    // register blocks listen only
    modport sink (
        input wen, blk_wen, waddr, wdata
    );

endinterface

//--- design/cur_cmd_regs.sv
// current command registers: four dac commands, read-back and dac update request
`timescale 1ns/1ps
`include "qla_macros.svh"

module cur_cmd_regs import qla_pkg::*; (
    input  logic         sysclk,
    input  logic         arst_n,
    reg_write_if.sink    bus,
    input  reg_addr_t    reg_raddr,
    output reg_data_t    reg_rdata,
    output cur_cmd_t     cur_cmd_1,
    output cur_cmd_t     cur_cmd_2,
    output cur_cmd_t     cur_cmd_3,
    output cur_cmd_t     cur_cmd_4,
    input  logic         dac_busy,
    output logic         cur_cmd_updated     // one-cycle load strobe to the dac
);

    cur_cmd_t cmd_q [1:`QLA_NUM_CHANNELS];
    chan_t    wr_chan;
    chan_t    rd_chan;
    logic     wr_hit;      // write hits a command register
    logic     rd_hit;
    logic     cmd_req;     // update pending, waits for the dac

    // main space, channel 1..4, dac offset; channel 0 is global
    function automatic logic is_cmd_addr(input reg_addr_t addr);
        return (addr[15:12] == `QLA_ADDR_MAIN)
            && (addr[7:4] != 4'd0)
            && (addr[7:4] <= chan_t'(`QLA_NUM_CHANNELS))
            && (addr[3:0] == `QLA_OFF_DAC_CTRL);
    endfunction

    assign wr_chan = chan_t'(bus.waddr[7:4]);
    assign rd_chan = chan_t'(reg_raddr[7:4]);
    assign wr_hit  = is_cmd_addr(bus.waddr);
    assign rd_hit  = is_cmd_addr(reg_raddr);

    // ----------------------------------------
    // commands and update request
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i <= `QLA_NUM_CHANNELS; i++) begin
                cmd_q[i] <= '0;
            end
            cmd_req         <= 1'b0;
            cur_cmd_updated <= 1'b0;
        end else begin
            if (wr_hit) begin
                if (bus.wen) begin
                    cmd_q[wr_chan] <= bus.wdata[15:0];
                end
                cmd_req <= bus.blk_wen;  // quadlet writes do not request
            end else if (cmd_req && !dac_busy) begin
                cmd_req <= 1'b0;         // dac took it
            end
            cur_cmd_updated <= cmd_req && !dac_busy;
        end
    end

    // read-back, zero outside the command registers
    assign reg_rdata = rd_hit ? reg_data_t'(cmd_q[rd_chan]) : '0;

    assign cur_cmd_1 = cmd_q[1];
    assign cur_cmd_2 = cmd_q[2];
    assign cur_cmd_3 = cmd_q[3];
    assign cur_cmd_4 = cmd_q[4];

endmodule

//--- design/qla_reg_core.sv
// qla register core: write arbitration, fir coefficient reload and current commands
`timescale 1ns/1ps

module qla_reg_core import qla_pkg::*; (
    input  logic         sysclk,
    input  logic         arst_n,
    // firewire write source
    input  logic         fw_reg_wen,
    input  logic         fw_blk_wen,
    input  reg_addr_t    fw_reg_waddr,
    input  reg_data_t    fw_reg_wdata,
    // ethernet write source
    input  logic         eth_reg_wen,
    input  logic         eth_blk_wen,
    input  reg_addr_t    eth_reg_waddr,
    input  reg_data_t    eth_reg_wdata,
    // real-time block write source
    input  logic         bw_reg_wen,
    input  logic         bw_blk_wen,
    input  logic [7:0]   bw_reg_waddr,
    input  reg_data_t    bw_reg_wdata,
    input  logic         eth_write_en,     // ethernet owns the write bus
    input  logic         bw_write_en,      // block write owns the write bus
    // register read
    input  reg_addr_t    reg_raddr,
    output reg_data_t    reg_rdata,
    // pot filter reload
    output logic         pot_reload_valid,
    output logic         pot_reload_last,
    output coeff_t       pot_coeff,
    input  logic         pot_reload_ready,
    // cur filter reload
    output logic         cur_reload_valid,
    output logic         cur_reload_last,
    output coeff_t       cur_coeff,
    input  logic         cur_reload_ready,
    // dac
    output cur_cmd_t     cur_cmd_1,
    output cur_cmd_t     cur_cmd_2,
    output cur_cmd_t     cur_cmd_3,
    output cur_cmd_t     cur_cmd_4,
    input  logic         dac_busy,
    output logic         cur_cmd_updated
);

    reg_write_if wbus ();   // arbitrated write bus

    // ----------------------------------------
    // write bus
    // ----------------------------------------
    write_bus_arbiter arbiter (
        .fw_reg_wen    (fw_reg_wen),
        .fw_blk_wen    (fw_blk_wen),
        .fw_reg_waddr  (fw_reg_waddr),
        .fw_reg_wdata  (fw_reg_wdata),
        .eth_reg_wen   (eth_reg_wen),
        .eth_blk_wen   (eth_blk_wen),
        .eth_reg_waddr (eth_reg_waddr),
        .eth_reg_wdata (eth_reg_wdata),
        .bw_reg_wen    (bw_reg_wen),
        .bw_blk_wen    (bw_blk_wen),
        .bw_reg_waddr  (bw_reg_waddr),
        .bw_reg_wdata  (bw_reg_wdata),
        .eth_write_en  (eth_write_en),
        .bw_write_en   (bw_write_en),
        .bus           (wbus.source)
    );

    // ----------------------------------------
    // fir reload, addr bit 11 picks the filter
    // ----------------------------------------
    coeff_loader #(.FIR_SEL(1'b1)) pot_loader (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .bus          (wbus.sink),
        .reload_valid (pot_reload_valid),
        .reload_last  (pot_reload_last),
        .reload_coeff (pot_coeff),
        .reload_ready (pot_reload_ready)
    );

    coeff_loader #(.FIR_SEL(1'b0)) cur_loader (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .bus          (wbus.sink),
        .reload_valid (cur_reload_valid),
        .reload_last  (cur_reload_last),
        .reload_coeff (cur_coeff),
        .reload_ready (cur_reload_ready)
    );

    // ----------------------------------------
    // commanded current, only read source left
    // ----------------------------------------
    cur_cmd_regs cmd_regs (
        .sysclk          (sysclk),
        .arst_n          (arst_n),
        .bus             (wbus.sink),
        .reg_raddr       (reg_raddr),
        .reg_rdata       (reg_rdata),
        .cur_cmd_1       (cur_cmd_1),
        .cur_cmd_2       (cur_cmd_2),
        .cur_cmd_3       (cur_cmd_3),
        .cur_cmd_4       (cur_cmd_4),
        .dac_busy        (dac_busy),
        .cur_cmd_updated (cur_cmd_updated)
    );

endmodule

//--- design/write_bus_arbiter.sv
// write bus arbiter: fixed priority pick of block-write, ethernet or firewire writes
`timescale 1ns/1ps

module write_bus_arbiter import qla_pkg::*; (
    // firewire, lowest priority and the default owner
    input  logic         fw_reg_wen,
    input  logic         fw_blk_wen,
    input  reg_addr_t    fw_reg_waddr,
    input  reg_data_t    fw_reg_wdata,
    // ethernet
    input  logic         eth_reg_wen,
    input  logic         eth_blk_wen,
    input  reg_addr_t    eth_reg_waddr,
    input  reg_data_t    eth_reg_wdata,
    // real-time block write, highest priority
    input  logic         bw_reg_wen,
    input  logic         bw_blk_wen,
    input  logic [7:0]   bw_reg_waddr,   // main space only, short address
    input  reg_data_t    bw_reg_wdata,
    // ownership flags
    input  logic         eth_write_en,
    input  logic         bw_write_en,
    reg_write_if.source  bus
);

    // whole bundle switches together, no mixing of sources
    always_comb begin
        if (bw_write_en) begin
            bus.wen     = bw_reg_wen;
            bus.blk_wen = bw_blk_wen;
            bus.waddr   = reg_addr_t'(bw_reg_waddr);   // zero-extend into main space
            bus.wdata   = bw_reg_wdata;
        end else if (eth_write_en) begin
            bus.wen     = eth_reg_wen;
            bus.blk_wen = eth_blk_wen;
            bus.waddr   = eth_reg_waddr;
            bus.wdata   = eth_reg_wdata;
        end else begin
            // firewire owns the bus when nobody else asks
            bus.wen     = fw_reg_wen;
            bus.blk_wen = fw_blk_wen;
            bus.waddr   = fw_reg_waddr;
            bus.wdata   = fw_reg_wdata;
        end
    end

endmodule

//--- files.f
+incdir+common
common/qla_pkg.sv
common/reg_write_if.sv
design/write_bus_arbiter.sv
fir_reload/coeff_loader.sv
design/cur_cmd_regs.sv
design/qla_reg_core.sv
tests/tb_qla_reg_core.sv

//--- fir_reload/coeff_loader.sv
// coeff loader: stages one filter's coefficient set and streams it over valid/ready/last
`timescale 1ns/1ps
`include "qla_macros.svh"

module coeff_loader import qla_pkg::*; #(
    parameter bit FIR_SEL = 1'b1          // addr bit 11 value this filter answers to
) (
    input  logic         sysclk,
    input  logic         arst_n,
    reg_write_if.sink    bus,
    output logic         reload_valid,
    output logic         reload_last,
    output coeff_t       reload_coeff,
    input  logic         reload_ready
);

    localparam coeff_idx_t LAST_IDX = coeff_idx_t'(`QLA_NUM_COEFFS - 1);

    reload_state_t state;
    coeff_t        coeff_arr [`QLA_NUM_COEFFS];   // staging array
    coeff_idx_t    wr_idx;                       // tap being written
    coeff_idx_t    rd_idx;                       // tap being offered
    logic          fir_hit;                      // write lands in this filter
    logic          stage_wen;                    // write actually stored
    logic          xfer;                         // handshake this cycle

    // ----------------------------------------
    // write decode
    // ----------------------------------------
    assign wr_idx  = coeff_idx_t'(bus.waddr[3:0]);
    assign fir_hit = bus.wen
                  && (bus.waddr[15:12] == `QLA_ADDR_FIR)
                  && (bus.waddr[`QLA_FIR_SEL_BIT] == FIR_SEL);

    // locked out while streaming, index 15 has no slot
    assign stage_wen = fir_hit && (state == ST_STAGING) && (wr_idx <= LAST_IDX);

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `QLA_NUM_COEFFS; i++) begin
                coeff_arr[i] <= '0;
            end
        end else if (stage_wen) begin
            coeff_arr[wr_idx] <= bus.wdata[15:0];  // low half carries the tap
        end
    end

    // ----------------------------------------
    // reload fsm
    // ----------------------------------------
    assign xfer = reload_valid && reload_ready;

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= ST_STAGING;
            rd_idx <= '0;
        end else begin
            case (state)
                ST_STAGING: begin
                    // last tap written, set is complete
                    if (stage_wen && (wr_idx == LAST_IDX)) begin
                        state  <= ST_STREAMING;
                        rd_idx <= '0;
                    end
                end
                ST_STREAMING: begin
                    if (xfer) begin
                        if (rd_idx == LAST_IDX) begin
                            state  <= ST_STAGING;    // reopen staging
                            rd_idx <= '0;
                        end else begin
                            rd_idx <= rd_idx + 1'b1;  // next tap
                        end
                    end
                end
            endcase
        end
    end

    // outputs hold while ready is low, index only moves on xfer
    assign reload_valid = (state == ST_STREAMING);
    assign reload_last  = reload_valid && (rd_idx == LAST_IDX);
    assign reload_coeff = coeff_arr[rd_idx];

endmodule

//--- tests/tb_qla_reg_core.sv
// testbench for the qla register core covering write priority, commands, dac update and fir reload
`timescale 1ns/1ps
`include "qla_macros.svh"

module tb_qla_reg_core import qla_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int PRIO_ROUNDS  = 24;
    localparam int STREAM_LIMIT = 200;   // cycles allowed for one 15-tap stream
    // reset, priority rounds, filter/dac tests, two streams with staging
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 * PRIO_ROUNDS + 60
                                + 2 * (`QLA_NUM_COEFFS + 4 + STREAM_LIMIT);
    localparam int WATCHDOG_NS  = (TEST_CYCLES + TEST_CYCLES / 4) * CLK_PERIOD;

    logic      sysclk;
    logic      arst_n;
    logic      fw_reg_wen, fw_blk_wen;
    reg_addr_t fw_reg_waddr;
    reg_data_t fw_reg_wdata;
    logic      eth_reg_wen, eth_blk_wen;
    reg_addr_t eth_reg_waddr;
    reg_data_t eth_reg_wdata;
    logic      bw_reg_wen, bw_blk_wen;
    logic [7:0] bw_reg_waddr;
    reg_data_t bw_reg_wdata;
    logic      eth_write_en, bw_write_en;
    reg_addr_t reg_raddr;
    reg_data_t reg_rdata;
    logic      pot_reload_valid, pot_reload_last, pot_reload_ready;
    coeff_t    pot_coeff;
    logic      cur_reload_valid, cur_reload_last, cur_reload_ready;
    coeff_t    cur_coeff;
    cur_cmd_t  cur_cmd_1, cur_cmd_2, cur_cmd_3, cur_cmd_4;
    logic      dac_busy;
    logic      cur_cmd_updated;

    integer    seed = 47;
    integer    ready_seed = 48;               // separate stream for the ready process
    reg_data_t ready_rnd;
    logic      cur_hold;                      // forces cur ready low to stall the stream
    int        errors = 0;
    int        checks = 0;
    int        pulse_count;
    cur_cmd_t  cmd_model [1:`QLA_NUM_CHANNELS];
    coeff_t    pot_exp_q [$];                 // taps still due on each stream
    coeff_t    cur_exp_q [$];

    qla_reg_core uut (.*);

    initial begin
        sysclk = 1'b0;
        forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
    end

    // ----------------------------------------
    // reference models
    // ----------------------------------------
    // {wen, data} of the source that should own the bus
    function automatic logic [32:0] arb_ref(input logic bw_en, input logic eth_en,
            input logic [32:0] fw_w, input logic [32:0] eth_w, input logic [32:0] bw_w);
        if (bw_en) return bw_w;
        else if (eth_en) return eth_w;
        return fw_w;
    endfunction

    function automatic reg_data_t read_ref(input reg_addr_t addr);
        int ch;
        ch = int'(addr[7:4]);
        if (addr[15:12] == `QLA_ADDR_MAIN && ch >= 1 && ch <= `QLA_NUM_CHANNELS
                && addr[3:0] == `QLA_OFF_DAC_CTRL)
            return reg_data_t'(cmd_model[ch]);
        return '0;                            // nothing else is readable
    endfunction

    function automatic reg_addr_t cmd_addr(input int ch);
        return {`QLA_ADDR_MAIN, 4'h0, 4'(ch), `QLA_OFF_DAC_CTRL};
    endfunction

    function automatic reg_addr_t fir_addr(input logic sel, input int idx);
        return {`QLA_ADDR_FIR, sel, 7'h00, 4'(idx)};   // sel lands on bit 11
    endfunction

    // ----------------------------------------
    // helpers entered right after a falling edge
    // ----------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic idle_bus();
        fw_reg_wen   = 1'b0;
        fw_blk_wen   = 1'b0;
        eth_reg_wen  = 1'b0;
        eth_blk_wen  = 1'b0;
        bw_reg_wen   = 1'b0;
        bw_blk_wen   = 1'b0;
        eth_write_en = 1'b0;
        bw_write_en  = 1'b0;
    endtask

    task automatic fw_write(input reg_addr_t addr, input reg_data_t data);
        fw_reg_wen   = 1'b1;
        fw_reg_waddr = addr;
        fw_reg_wdata = data;
        @(negedge sysclk);
        fw_reg_wen   = 1'b0;
    endtask

    task automatic check_read(input reg_addr_t addr);
        reg_raddr = addr;
        #1;                                   // rdata settles mid low phase
        check_value("reg_rdata", reg_rdata, read_ref(addr));
        @(negedge sysclk);
    endtask

    task automatic check_outputs();
        check_value("cur_cmd_1", 32'(cur_cmd_1), 32'(cmd_model[1]));
        check_value("cur_cmd_2", 32'(cur_cmd_2), 32'(cmd_model[2]));
        check_value("cur_cmd_3", 32'(cur_cmd_3), 32'(cmd_model[3]));
        check_value("cur_cmd_4", 32'(cur_cmd_4), 32'(cmd_model[4]));
    endtask

    // ----------------------------------------
    // stream compare on pre-edge values at each rising edge
    // ----------------------------------------
    always @(posedge sysclk) begin
        if (arst_n && pot_reload_valid && pot_reload_ready) begin
            if (pot_exp_q.size() == 0) begin
                errors++;
                $display("pot stream delivered a coefficient that was never staged");
            end else begin
                check_value("pot_reload_last", 32'(pot_reload_last), 32'(pot_exp_q.size() == 1));
                check_value("pot_coeff", 32'(pot_coeff), 32'(pot_exp_q.pop_front()));
            end
        end
    end

    always @(posedge sysclk) begin
        if (arst_n && cur_reload_valid && cur_reload_ready) begin
            if (cur_exp_q.size() == 0) begin
                errors++;
                $display("cur stream delivered a coefficient that was never staged");
            end else begin
                check_value("cur_reload_last", 32'(cur_reload_last), 32'(cur_exp_q.size() == 1));
                check_value("cur_coeff", 32'(cur_coeff), 32'(cur_exp_q.pop_front()));
            end
        end
    end

    always @(posedge sysclk) begin
        if (arst_n && cur_cmd_updated) pulse_count++;   // dac strobes seen
    end

    // random back-pressure on both filter streams
    always @(negedge sysclk) begin
        ready_rnd = $random(ready_seed);
        pot_reload_ready <= ready_rnd[0];
        cur_reload_ready <= cur_hold ? 1'b0 : ready_rnd[1];
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin
        reg_data_t   r;
        reg_data_t   fw_d, eth_d, bw_d;
        logic [32:0] pick;
        int          ch;
        arst_n        = 1'b0;
        idle_bus();
        fw_reg_waddr  = '0;
        fw_reg_wdata  = '0;
        eth_reg_waddr = '0;
        eth_reg_wdata = '0;
        bw_reg_waddr  = '0;
        bw_reg_wdata  = '0;
        reg_raddr     = '0;
        pot_reload_ready = 1'b0;
        cur_reload_ready = 1'b0;
        dac_busy      = 1'b0;
        cur_hold      = 1'b0;
        pulse_count   = 0;
        for (int i = 1; i <= `QLA_NUM_CHANNELS; i++) cmd_model[i] = '0;
        repeat (RESET_CYCLES) @(negedge sysclk);
        arst_n = 1'b1;
        check_value("pot_reload_valid", 32'(pot_reload_valid), 32'(0));
        check_value("cur_reload_valid", 32'(cur_reload_valid), 32'(0));
        check_value("cur_cmd_updated", 32'(cur_cmd_updated), 32'(0));
        check_outputs();

        // write priority with all three sources aimed at one channel
        for (int n = 0; n < PRIO_ROUNDS; n++) begin
            r  = $random(seed);
            ch = 1 + int'(r[1:0]);
            bw_write_en   = r[2];
            eth_write_en  = r[3];
            fw_reg_wen    = r[4];
            eth_reg_wen   = r[5];
            bw_reg_wen    = r[6];
            fw_d          = $random(seed);
            eth_d         = $random(seed);
            bw_d          = $random(seed);
            fw_reg_waddr  = cmd_addr(ch);
            eth_reg_waddr = cmd_addr(ch);
            bw_reg_waddr  = {4'(ch), `QLA_OFF_DAC_CTRL};   // short block-write address
            fw_reg_wdata  = fw_d;
            eth_reg_wdata = eth_d;
            bw_reg_wdata  = bw_d;
            pick = arb_ref(bw_write_en, eth_write_en, {fw_reg_wen, fw_d},
                           {eth_reg_wen, eth_d}, {bw_reg_wen, bw_d});
            if (pick[32]) cmd_model[ch] = pick[15:0];
            @(negedge sysclk);
            idle_bus();
            check_read(cmd_addr(ch));
            check_outputs();
        end

        // channel 0, channels 5..15, other offsets and spaces change nothing
        fw_blk_wen = 1'b1;                    // a missed decode would also raise a request
        fw_write(cmd_addr(0), $random(seed));
        for (int c = 5; c < 16; c++) fw_write(cmd_addr(c), $random(seed));
        fw_write({`QLA_ADDR_MAIN, 4'h0, 4'h1, 4'h2}, $random(seed));
        fw_write({`QLA_ADDR_MAIN, 4'h0, 4'h3, 4'h0}, $random(seed));
        fw_write({4'h1, 4'h0, 4'h2, `QLA_OFF_DAC_CTRL}, $random(seed));
        check_outputs();
        check_read(cmd_addr(0));
        check_read(cmd_addr(7));
        check_read(16'h0012);
        check_read(16'h1021);
        check_value("cur_cmd_updated pulses on filtered writes", 32'(pulse_count), 32'(0));
        fw_blk_wen = 1'b0;

        // dac update with the block write held off by busy
        dac_busy     = 1'b1;
        pulse_count  = 0;
        bw_write_en  = 1'b1;
        bw_reg_wen   = 1'b1;
        bw_blk_wen   = 1'b1;
        bw_reg_waddr = {4'd2, `QLA_OFF_DAC_CTRL};
        bw_reg_wdata = $random(seed);
        cmd_model[2] = bw_reg_wdata[15:0];
        @(negedge sysclk);
        idle_bus();
        repeat (10) @(negedge sysclk);
        check_value("cur_cmd_updated pulses while busy", 32'(pulse_count), 32'(0));
        dac_busy = 1'b0;
        repeat (2) @(negedge sysclk);         // request clears and one strobe follows
        check_value("cur_cmd_updated pulses after busy", 32'(pulse_count), 32'(1));
        repeat (4) @(negedge sysclk);
        check_value("cur_cmd_updated pulses later", 32'(pulse_count), 32'(1));
        r = $random(seed);
        cmd_model[3] = r[15:0];
        fw_write(cmd_addr(3), r);             // quadlet only so no request
        repeat (4) @(negedge sysclk);
        check_value("cur_cmd_updated pulses on quadlet", 32'(pulse_count), 32'(1));
        check_outputs();

        // pot staging and stream under random ready
        for (int i = 0; i < `QLA_NUM_COEFFS; i++) begin
            r = $random(seed);
            pot_exp_q.push_back(r[15:0]);
            fw_write(fir_addr(1'b1, i), r);
        end
        check_value("pot_reload_valid", 32'(pot_reload_valid), 32'(1));
        check_value("cur_reload_valid", 32'(cur_reload_valid), 32'(0));
        for (int n = 0; n < STREAM_LIMIT && pot_exp_q.size() != 0; n++) @(negedge sysclk);
        if (pot_exp_q.size() != 0) begin
            errors++;
            $display("pot stream stalled with %0d coefficients missing", pot_exp_q.size());
        end
        check_value("pot_reload_valid", 32'(pot_reload_valid), 32'(0));

        // cur staging where index 15 and writes during streaming must not matter
        cur_hold = 1'b1;
        for (int i = 0; i < `QLA_NUM_COEFFS - 1; i++) begin
            r = $random(seed);
            cur_exp_q.push_back(r[15:0]);
            fw_write(fir_addr(1'b0, i), r);
        end
        fw_write(fir_addr(1'b0, 15), $random(seed));
        check_value("cur_reload_valid", 32'(cur_reload_valid), 32'(0));
        r = $random(seed);
        cur_exp_q.push_back(r[15:0]);
        fw_write(fir_addr(1'b0, `QLA_NUM_COEFFS - 1), r);
        check_value("cur_reload_valid", 32'(cur_reload_valid), 32'(1));
        fw_write(fir_addr(1'b0, 0), $random(seed));
        fw_write(fir_addr(1'b0, 7), $random(seed));
        fw_write(fir_addr(1'b0, `QLA_NUM_COEFFS - 1), $random(seed));
        check_value("pot_reload_valid", 32'(pot_reload_valid), 32'(0));
        cur_hold = 1'b0;
        for (int n = 0; n < STREAM_LIMIT && cur_exp_q.size() != 0; n++) @(negedge sysclk);
        if (cur_exp_q.size() != 0) begin
            errors++;
            $display("cur stream stalled with %0d coefficients missing", cur_exp_q.size());
        end
        check_value("cur_reload_valid", 32'(cur_reload_valid), 32'(0));

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // run length bound sized from the test lengths above
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("test failed");
        $finish;
    end

endmodule
